/* design/tdd_pkg.sv */
// TDD controller shared definitions
// register map, control and status bit positions and the bus width
// used by the register slave and the device interface

package tdd_pkg;

  // Wishbone data bus width
  parameter int wb_data_w = 32;

  // **************************************************
  // register word addresses
  // **************************************************
  parameter logic [3:0] reg_control    = 4'd0;
  parameter logic [3:0] reg_frame_len  = 4'd1;
  parameter logic [3:0] reg_rx_vco_on  = 4'd2;
  parameter logic [3:0] reg_rx_vco_off = 4'd3;
  parameter logic [3:0] reg_tx_vco_on  = 4'd4;
  parameter logic [3:0] reg_tx_vco_off = 4'd5;
  parameter logic [3:0] reg_rx_rf_on   = 4'd6;
  parameter logic [3:0] reg_rx_rf_off  = 4'd7;
  parameter logic [3:0] reg_tx_rf_on   = 4'd8;
  parameter logic [3:0] reg_tx_rf_off  = 4'd9;
  // read only, writes to it are acked and dropped
  parameter logic [3:0] reg_status     = 4'd10;

  // bit positions inside the control register
  parameter int ctrl_enable_bit     = 0;
  parameter int ctrl_level_mode_bit = 1;

  // bit positions inside the 8-bit status word, the rest read zero
  parameter int status_vco_overlap_bit = 0;
  parameter int status_rf_overlap_bit  = 1;

endpackage

/* design/tdd_regs.sv */
// TDD register slave
// Wishbone classic slave holding the control, frame length and the
// four on/off window pairs, with a read-only status word

module tdd_regs #(
  parameter int count_w = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [3:0]                    wb_adr,
  input  logic [tdd_pkg::wb_data_w-1:0] wb_dat_w,
  input  logic [7:0]                    status,
  output logic [tdd_pkg::wb_data_w-1:0] wb_dat_r,
  output logic                          wb_ack,
  output logic                          tdd_enable,
  output logic                          level_mode,
  output logic [count_w-1:0]            frame_len,
  output logic [count_w-1:0]            rx_vco_on,
  output logic [count_w-1:0]            rx_vco_off,
  output logic [count_w-1:0]            tx_vco_on,
  output logic [count_w-1:0]            tx_vco_off,
  output logic [count_w-1:0]            rx_rf_on,
  output logic [count_w-1:0]            rx_rf_off,
  output logic [count_w-1:0]            tx_rf_on,
  output logic [count_w-1:0]            tx_rf_off
);

  // a new request is seen only while no ack is pending, so a master that
  // holds stb for the ack cycle does not trigger a second access
  logic                          wb_req;
  logic [tdd_pkg::wb_data_w-1:0] rd_data;

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;

  // **************************************************
  // write side and ack
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack     <= 1'b0;
      tdd_enable <= 1'b0;
      level_mode <= 1'b0;
      frame_len  <= '0;
      rx_vco_on  <= '0;
      rx_vco_off <= '0;
      tx_vco_on  <= '0;
      tx_vco_off <= '0;
      rx_rf_on   <= '0;
      rx_rf_off  <= '0;
      tx_rf_on   <= '0;
      tx_rf_off  <= '0;
    end else begin
      wb_ack <= wb_req;
      // the write lands on the same edge that raises the ack
      if (wb_req && wb_we) begin
        case (wb_adr)
          tdd_pkg::reg_control: begin
            tdd_enable <= wb_dat_w[tdd_pkg::ctrl_enable_bit];
            level_mode <= wb_dat_w[tdd_pkg::ctrl_level_mode_bit];
          end
          // counts keep only the low count_w bits of the bus word
          tdd_pkg::reg_frame_len:  frame_len  <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_rx_vco_on:  rx_vco_on  <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_rx_vco_off: rx_vco_off <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_tx_vco_on:  tx_vco_on  <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_tx_vco_off: tx_vco_off <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_rx_rf_on:   rx_rf_on   <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_rx_rf_off:  rx_rf_off  <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_tx_rf_on:   tx_rf_on   <= wb_dat_w[count_w-1:0];
          tdd_pkg::reg_tx_rf_off:  tx_rf_off  <= wb_dat_w[count_w-1:0];
          default: ;
        endcase
      end
    end
  end

  // **************************************************
  // read side
  // **************************************************

  // read mux, values are zero extended and unmapped words read zero
  always_comb begin
    rd_data = '0;
    case (wb_adr)
      tdd_pkg::reg_control: begin
        rd_data[tdd_pkg::ctrl_enable_bit]     = tdd_enable;
        rd_data[tdd_pkg::ctrl_level_mode_bit] = level_mode;
      end
      tdd_pkg::reg_frame_len:  rd_data[count_w-1:0] = frame_len;
      tdd_pkg::reg_rx_vco_on:  rd_data[count_w-1:0] = rx_vco_on;
      tdd_pkg::reg_rx_vco_off: rd_data[count_w-1:0] = rx_vco_off;
      tdd_pkg::reg_tx_vco_on:  rd_data[count_w-1:0] = tx_vco_on;
      tdd_pkg::reg_tx_vco_off: rd_data[count_w-1:0] = tx_vco_off;
      tdd_pkg::reg_rx_rf_on:   rd_data[count_w-1:0] = rx_rf_on;
      tdd_pkg::reg_rx_rf_off:  rd_data[count_w-1:0] = rx_rf_off;
      tdd_pkg::reg_tx_rf_on:   rd_data[count_w-1:0] = tx_rf_on;
      tdd_pkg::reg_tx_rf_off:  rd_data[count_w-1:0] = tx_rf_off;
      // status is sampled live from the device interface
      tdd_pkg::reg_status:     rd_data[7:0] = status;
      default: ;
    endcase
  end

  // read data only matters while wb_ack is high
  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

endmodule

/* design/tdd_frame_counter.sv */
// TDD frame counter
// first pipeline stage, counts through the frame while enabled and
// wraps at the programmed frame length, holds zero while disabled

module tdd_frame_counter #(
  parameter int count_w = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               tdd_enable,
  input  logic [count_w-1:0] frame_len,
  output logic [count_w-1:0] count
);

  // last count value of a frame
  logic [count_w-1:0] last_count;

  // a zero frame length behaves like a one-cycle frame
  assign last_count = (frame_len == '0) ? '0 : frame_len - 1'b1;

  // **************************************************
  // counter
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (!tdd_enable) begin
      // disabled, so the next frame starts from zero again
      count <= '0;
    end else if (count >= last_count) begin
      // greater-or-equal also catches a frame length shortened mid-frame
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* design/tdd_window_gen.sv */
// TDD window generator
// second pipeline stage, compares the frame count against the four
// on/off pairs and registers one enable per window

module tdd_window_gen #(
  parameter int count_w = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [count_w-1:0] count,
  input  logic [count_w-1:0] rx_vco_on,
  input  logic [count_w-1:0] rx_vco_off,
  input  logic [count_w-1:0] tx_vco_on,
  input  logic [count_w-1:0] tx_vco_off,
  input  logic [count_w-1:0] rx_rf_on,
  input  logic [count_w-1:0] rx_rf_off,
  input  logic [count_w-1:0] tx_rf_on,
  input  logic [count_w-1:0] tx_rf_off,
  output logic               rx_vco_en,
  output logic               tx_vco_en,
  output logic               rx_rf_en,
  output logic               tx_rf_en
);

  // a window covers the half-open range [on, off)
  // with on >= off the range is empty, so the window never opens
  function automatic logic in_window(
    input logic [count_w-1:0] cnt,
    input logic [count_w-1:0] on_val,
    input logic [count_w-1:0] off_val
  );
    return (cnt >= on_val) && (cnt < off_val);
  endfunction

  // **************************************************
  // registered comparators
  // **************************************************

  // each enable follows the count one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_vco_en <= 1'b0;
      tx_vco_en <= 1'b0;
      rx_rf_en  <= 1'b0;
      tx_rf_en  <= 1'b0;
    end else begin
      rx_vco_en <= in_window(count, rx_vco_on, rx_vco_off);
      tx_vco_en <= in_window(count, tx_vco_on, tx_vco_off);
      rx_rf_en  <= in_window(count, rx_rf_on, rx_rf_off);
      tx_rf_en  <= in_window(count, tx_rf_on, tx_rf_off);
    end
  end

endmodule

/* design/tdd_device_if.sv */
// TDD device interface
// third pipeline stage, drives the transceiver txnrx and enable pins
// in level or pulse mode and flags overlapping rx/tx windows

module tdd_device_if (
  input  logic       clk,
  input  logic       rst,
  input  logic       level_mode,
  input  logic       rx_vco_en,
  input  logic       tx_vco_en,
  input  logic       rx_rf_en,
  input  logic       tx_rf_en,
  output logic       txnrx,
  output logic       enable,
  output logic [7:0] status
);

  logic rx_rf_en_d;
  logic tx_rf_en_d;
  logic vco_overlap;
  logic rf_overlap;
  logic rf_edge;

  // only one VCO may run, rx wins when both windows are open
  assign txnrx = tx_vco_en & ~rx_vco_en;

  // **************************************************
  // enable pin
  // **************************************************

  // delayed copies of the rf enables for edge detection
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_rf_en_d <= 1'b0;
      tx_rf_en_d <= 1'b0;
    end else begin
      rx_rf_en_d <= rx_rf_en;
      tx_rf_en_d <= tx_rf_en;
    end
  end

  // any rise or fall of either rf enable gives a one-cycle pulse
  assign rf_edge = (rx_rf_en ^ rx_rf_en_d) | (tx_rf_en ^ tx_rf_en_d);

  // level mode follows the windows directly, pulse mode marks their edges
  assign enable = level_mode ? (rx_rf_en | tx_rf_en) : rf_edge;

  // **************************************************
  // overlap status
  // **************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      vco_overlap <= 1'b0;
      rf_overlap  <= 1'b0;
    end else begin
      vco_overlap <= rx_vco_en & tx_vco_en;
      rf_overlap  <= rx_rf_en & tx_rf_en;
    end
  end

  always_comb begin
    status = '0;
    status[tdd_pkg::status_vco_overlap_bit] = vco_overlap;
    status[tdd_pkg::status_rf_overlap_bit]  = rf_overlap;
  end

endmodule

/* design/tdd_ctrl_top.sv */
// TDD controller top level
// Wishbone register slave feeding the counter, window and device
// interface pipeline that drives the transceiver txnrx and enable pins

module tdd_ctrl_top #(
  parameter int count_w = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [3:0]                    wb_adr,
  input  logic [tdd_pkg::wb_data_w-1:0] wb_dat_w,
  output logic [tdd_pkg::wb_data_w-1:0] wb_dat_r,
  output logic                          wb_ack,
  output logic                          txnrx,
  output logic                          enable,
  output logic [7:0]                    tdd_status
);

  // configuration from the register slave
  logic               tdd_enable;
  logic               level_mode;
  logic [count_w-1:0] frame_len;
  logic [count_w-1:0] rx_vco_on;
  logic [count_w-1:0] rx_vco_off;
  logic [count_w-1:0] tx_vco_on;
  logic [count_w-1:0] tx_vco_off;
  logic [count_w-1:0] rx_rf_on;
  logic [count_w-1:0] rx_rf_off;
  logic [count_w-1:0] tx_rf_on;
  logic [count_w-1:0] tx_rf_off;

  // pipeline signals
  logic [count_w-1:0] count;
  logic               rx_vco_en;
  logic               tx_vco_en;
  logic               rx_rf_en;
  logic               tx_rf_en;

  // **************************************************
  // register slave
  // **************************************************
  tdd_regs #(
    .count_w (count_w)
  ) tdd_regs_i (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .status     (tdd_status),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .tdd_enable (tdd_enable),
    .level_mode (level_mode),
    .frame_len  (frame_len),
    .rx_vco_on  (rx_vco_on),
    .rx_vco_off (rx_vco_off),
    .tx_vco_on  (tx_vco_on),
    .tx_vco_off (tx_vco_off),
    .rx_rf_on   (rx_rf_on),
    .rx_rf_off  (rx_rf_off),
    .tx_rf_on   (tx_rf_on),
    .tx_rf_off  (tx_rf_off)
  );

  // **************************************************
  // pipeline, count then windows then pins
  // **************************************************
  tdd_frame_counter #(
    .count_w (count_w)
  ) tdd_frame_counter_i (
    .clk        (clk),
    .rst        (rst),
    .tdd_enable (tdd_enable),
    .frame_len  (frame_len),
    .count      (count)
  );

  tdd_window_gen #(
    .count_w (count_w)
  ) tdd_window_gen_i (
    .clk        (clk),
    .rst        (rst),
    .count      (count),
    .rx_vco_on  (rx_vco_on),
    .rx_vco_off (rx_vco_off),
    .tx_vco_on  (tx_vco_on),
    .tx_vco_off (tx_vco_off),
    .rx_rf_on   (rx_rf_on),
    .rx_rf_off  (rx_rf_off),
    .tx_rf_on   (tx_rf_on),
    .tx_rf_off  (tx_rf_off),
    .rx_vco_en  (rx_vco_en),
    .tx_vco_en  (tx_vco_en),
    .rx_rf_en   (rx_rf_en),
    .tx_rf_en   (tx_rf_en)
  );

  // pins lag the count by one cycle, status by two
  tdd_device_if tdd_device_if_i (
    .clk        (clk),
    .rst        (rst),
    .level_mode (level_mode),
    .rx_vco_en  (rx_vco_en),
    .tx_vco_en  (tx_vco_en),
    .rx_rf_en   (rx_rf_en),
    .tx_rf_en   (tx_rf_en),
    .txnrx      (txnrx),
    .enable     (enable),
    .status     (tdd_status)
  );

endmodule

/* verif/tdd_ctrl_checker.sv */
// TDD device interface checker
// concurrent properties on the txnrx and enable pins and the status
// word, bound into every device interface instance

module tdd_ctrl_checker (
  input logic       clk,
  input logic       rst,
  input logic       level_mode,
  input logic       rx_rf_en,
  input logic       tx_rf_en,
  input logic       txnrx,
  input logic       enable,
  input logic [7:0] status
);
  timeunit 1ns;
  timeprecision 1ps;

  // a pulse only ever marks a change of an rf enable since the last edge
  pulse_on_rf_edge: assert property (@(posedge clk) disable iff (rst)
    (!level_mode && enable) |->
      (rx_rf_en != $past(rx_rf_en) || tx_rf_en != $past(tx_rf_en)))
    else $error("enable pulse without an rf window edge");

  // from the second reset cycle on, every flop has cleared
  pins_low_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!enable && !txnrx && status == 8'h00))
    else $error("device pins not low during reset");

  // a pulse lasts one cycle only
  pulse_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (!level_mode && enable) |=> !enable)
    else $error("enable pulse longer than one cycle");

endmodule

bind tdd_device_if tdd_ctrl_checker tdd_ctrl_checker_i (.*);

/* verif/tdd_ctrl_tb.sv */
// TDD controller testbench
// register readback, then a table of window setups run in level and
// pulse mode and compared cycle by cycle against a frame model

module tdd_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int count_w = 16;
  localparam int n_cases = 5;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        txnrx;
  logic        enable;
  logic [7:0]  tdd_status;

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lcg_state;

  // **************************************************
  // case table, windows are rx VCO, tx VCO, rx RF, tx RF as on/off pairs
  // **************************************************
  string case_name[n_cases] = '{"level_disjoint", "level_overlap", "pulse_disjoint",
                                "pulse_overlap", "never_open"};
  bit    case_level[n_cases] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
  int    case_len[n_cases]   = '{12, 10, 16, 9, 8};
  int    case_win[n_cases][8] = '{'{1, 5, 6, 11, 2, 5, 7, 10},
                                  '{0, 6, 3, 9, 0, 4, 2, 7},
                                  '{2, 7, 8, 14, 3, 6, 9, 13},
                                  '{0, 5, 0, 5, 0, 3, 0, 5},
                                  '{5, 5, 6, 2, 4, 4, 7, 1}};

  tdd_ctrl_top #(
    .count_w (count_w)
  ) tdd_ctrl_top_i (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .txnrx      (txnrx),
    .enable     (enable),
    .tdd_status (tdd_status)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // window rule, half open range [on, off)
  function automatic bit in_win(int c, int on_val, int off_val);
    return (c >= on_val) && (c < off_val);
  endfunction

  // model count j cycles after enable, zero before it
  function automatic int count_at(int j, int len);
    return (j < 0) ? 0 : j % len;
  endfunction

  task automatic timeout_fail(string what);
    $display("timeout waiting for wb_ack on %s", what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic check_val(string test, string what, int k, logic [31:0] exp,
                           logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: %s at cycle %0d expected %0h actual %0h",
               test, what, k, exp, act);
      errors++;
    end
  endtask

  // each bus task starts and ends 1 ns after a rising edge
  task automatic wb_write(logic [3:0] adr, logic [31:0] data);
    int n;
    n = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = data;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!wb_ack && n < 20);
    if (!wb_ack) begin
      timeout_fail("write");
    end else begin
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we = 1'b0;
    end
  endtask

  task automatic wb_read(logic [3:0] adr, output logic [31:0] data);
    int n;
    n = 0;
    data = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!wb_ack && n < 20);
    if (!wb_ack) begin
      timeout_fail("read");
    end else begin
      data = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
    end
  endtask

  task automatic report(string test, int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s passed", test);
    end else begin
      $display("test %s failed", test);
      tests_failed++;
    end
  endtask

  // random words to every window and frame register, unmapped reads zero
  task automatic readback_test();
    int          e0;
    logic [31:0] v;
    logic [31:0] rd;
    e0 = errors;
    for (int a = 1; a < 16; a++) begin
      if (a != 10) begin
        v = lcg_next();
        wb_write(4'(a), v);
        wb_read(4'(a), rd);
        check_val("readback", "register word", a, (a <= 9) ? (v & 32'h0000ffff) : 32'h0, rd);
      end
    end
    report("readback", e0);
  endtask

  task automatic run_case(int idx);
    int          e0;
    int          len;
    bit          lvl;
    bit          en_now[4];
    bit          en_prev[4];
    bit          rf0;
    logic [31:0] rd;
    logic [7:0]  ov0;
    e0 = errors;
    len = (case_len[idx] == 0) ? 1 : case_len[idx];
    lvl = case_level[idx];
    wb_write(tdd_pkg::reg_frame_len, 32'(case_len[idx]));
    for (int i = 0; i < 8; i++) wb_write(4'(2 + i), 32'(case_win[idx][i]));
    wb_write(tdd_pkg::reg_control, {30'd0, lvl, 1'b1});
    // cycle k = 0 is the first enabled cycle, the count is 0 there
    for (int k = 0; k < 3 * len; k++) begin
      for (int w = 0; w < 4; w++) begin
        en_now[w] = in_win(count_at(k - 1, len), case_win[idx][2*w], case_win[idx][2*w+1]);
        en_prev[w] = in_win(count_at(k - 2, len), case_win[idx][2*w], case_win[idx][2*w+1]);
      end
      check_val(case_name[idx], "txnrx", k, 32'(en_now[1] & ~en_now[0]), 32'(txnrx));
      check_val(case_name[idx], "enable", k,
                lvl ? 32'(en_now[2] | en_now[3])
                    : 32'((en_now[2] ^ en_prev[2]) | (en_now[3] ^ en_prev[3])),
                32'(enable));
      check_val(case_name[idx], "status", k,
                32'({en_prev[2] & en_prev[3], en_prev[0] & en_prev[1]}), 32'(tdd_status));
      @(posedge clk);
      #1;
    end
    // disable, then the pins settle to the windows at count zero
    wb_write(tdd_pkg::reg_control, {30'd0, lvl, 1'b0});
    for (int w = 0; w < 4; w++) en_now[w] = in_win(0, case_win[idx][2*w], case_win[idx][2*w+1]);
    rf0 = en_now[2] | en_now[3];
    ov0 = {6'd0, en_now[2] & en_now[3], en_now[0] & en_now[1]};
    repeat (3) begin
      @(posedge clk);
      #1;
    end
    for (int k = 0; k < len; k++) begin
      check_val(case_name[idx], "idle count", k, 32'h0, 32'(tdd_ctrl_top_i.count));
      check_val(case_name[idx], "idle txnrx", k, 32'(en_now[1] & ~en_now[0]), 32'(txnrx));
      check_val(case_name[idx], "idle enable", k, lvl ? 32'(rf0) : 32'h0, 32'(enable));
      check_val(case_name[idx], "idle status", k, 32'(ov0), 32'(tdd_status));
      @(posedge clk);
      #1;
    end
    wb_read(tdd_pkg::reg_status, rd);
    check_val(case_name[idx], "reg_status", 0, 32'(ov0), rd);
    report(case_name[idx], e0);
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 4'd0;
    wb_dat_w = 32'd0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    lcg_state = 32'h6897;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    readback_test();
    for (int i = 0; i < n_cases; i++) run_case(i);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tdd_ctrl.f */
design/tdd_pkg.sv
design/tdd_regs.sv
design/tdd_frame_counter.sv
design/tdd_window_gen.sv
design/tdd_device_if.sv
design/tdd_ctrl_top.sv
verif/tdd_ctrl_checker.sv
verif/tdd_ctrl_tb.sv

/* Makefile */
# Verilator build and run for the TDD controller

TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = tdd_ctrl_tb
FILE_LIST = tdd_ctrl.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
